/* cache_pkg.sv */
package cache_pkg;

    // hart and memory word geometry
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int MASK_W         = DATA_W / 8;

    // 16 byte lines, so four words per line
    localparam int OFFSET_W       = 4;
    localparam int WORD_SEL_W     = 2;
    localparam int WORDS_PER_LINE = 2 ** WORD_SEL_W;

    // 32 sets of 2 ways gives 1 KiB in total
    localparam int SET_W          = 5;
    localparam int NUM_SETS       = 2 ** SET_W;
    localparam int TAG_W          = ADDR_W - SET_W - OFFSET_W;
    localparam int NUM_WAYS       = 2;

    // controller states, LOOKUP is the idle state
    typedef enum logic [1:0] {
        LOOKUP     = 2'd0,
        FILL_REQ   = 2'd1,
        FILL_WAIT  = 2'd2,
        WRITE_THRU = 2'd3
    } ctrl_state_t;

    // address field helpers shared by the stores
    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:SET_W+OFFSET_W];
    endfunction

    function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] addr);
        return addr[SET_W+OFFSET_W-1:OFFSET_W];
    endfunction

    function automatic logic [WORD_SEL_W-1:0] addr_word(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1:OFFSET_W-WORD_SEL_W];
    endfunction

endpackage

/* cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store import cache_pkg::*; (
    input  wire              i_clk,
    input  wire              i_rst,
    // address of the live hart request, used for hit detection
    input  wire [ADDR_W-1:0] i_req_addr,
    // captured address of the line being refilled
    input  wire [ADDR_W-1:0] i_fill_addr,
    // a hit was taken this cycle, point the set away from the hit way
    input  wire              i_hit_update,
    // last refill word lands this cycle, install the tag
    input  wire              i_fill_done,
    input  wire              i_fill_way,
    output logic             o_hit,
    output logic             o_hit_way,
    output logic             o_victim_way
);

    ////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////

    // tags carry no reset since a clear valid bit hides them
    logic [TAG_W-1:0]                   tag_q [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]  valid_q;
    // one bit per set naming the way to evict next
    logic [NUM_SETS-1:0]                repl_q;

    logic [TAG_W-1:0]    req_tag;
    logic [SET_W-1:0]    req_set;
    logic [TAG_W-1:0]    fill_tag;
    logic [SET_W-1:0]    fill_set;
    logic [NUM_WAYS-1:0] way_match;

    assign req_tag  = addr_tag(i_req_addr);
    assign req_set  = addr_set(i_req_addr);
    assign fill_tag = addr_tag(i_fill_addr);
    assign fill_set = addr_set(i_fill_addr);

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    // at most one way can match since a line is only ever filled once per set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid_q[w][req_set] && (tag_q[w][req_set] == req_tag);
        end
    end

    assign o_hit        = |way_match;
    assign o_hit_way    = way_match[1];
    // the victim is read at the captured set, which stays put for a whole refill
    assign o_victim_way = repl_q[fill_set];

    ////////////////////////////////////////////////////////////////////
    // updates
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_fill_done) begin
            tag_q[i_fill_way][fill_set] <= fill_tag;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= '0;
            repl_q  <= '0;
        end else begin
            if (i_fill_done) begin
                // the filled way becomes most recent, so flip the victim pointer
                valid_q[i_fill_way][fill_set] <= 1'b1;
                repl_q[fill_set]              <= ~repl_q[fill_set];
            end
            // hit updates only come from LOOKUP and fills only from FILL_WAIT
            if (i_hit_update) begin
                repl_q[req_set] <= ~o_hit_way;
            end
        end
    end

endmodule

`default_nettype wire

/* cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_store import cache_pkg::*; (
    input  wire                  i_clk,
    // read port, indexed by the live request and the way that hit
    input  wire [ADDR_W-1:0]     i_req_addr,
    input  wire                  i_hit_way,
    // refill port, one memory word per strobe
    input  wire                  i_fill_we,
    input  wire                  i_fill_way,
    input  wire [ADDR_W-1:0]     i_fill_addr,
    input  wire [WORD_SEL_W-1:0] i_fill_word_sel,
    input  wire [DATA_W-1:0]     i_mem_rdata,
    // store port, takes the merged word from the controller
    input  wire                  i_store_we,
    input  wire                  i_store_way,
    input  wire [ADDR_W-1:0]     i_store_addr,
    input  wire [DATA_W-1:0]     i_store_word,
    output logic [DATA_W-1:0]    o_rd_word
);

    ////////////////////////////////////////////////////////////////////
    // data arrays
    ////////////////////////////////////////////////////////////////////

    // two ways of 32 sets by 4 words each
    logic [DATA_W-1:0] data_q [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

    logic [SET_W-1:0]      req_set;
    logic [WORD_SEL_W-1:0] req_word;
    logic [SET_W-1:0]      fill_set;
    logic [SET_W-1:0]      store_set;
    logic [WORD_SEL_W-1:0] store_word_sel;

    assign req_set        = addr_set(i_req_addr);
    assign req_word       = addr_word(i_req_addr);
    assign fill_set       = addr_set(i_fill_addr);
    assign store_set      = addr_set(i_store_addr);
    assign store_word_sel = addr_word(i_store_addr);

    ////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////

    // combinational so that a load hit is answered in the request cycle
    // and the controller can merge a store against the current word
    assign o_rd_word = data_q[i_hit_way][req_set][req_word];

    ////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////

    // refill and store writes never overlap, the controller issues them
    // from different states
    always_ff @(posedge i_clk) begin
        if (i_fill_we) begin
            data_q[i_fill_way][fill_set][i_fill_word_sel] <= i_mem_rdata;
        end else if (i_store_we) begin
            data_q[i_store_way][store_set][store_word_sel] <= i_store_word;
        end
    end

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rst,
    // hart request
    input  wire  [ADDR_W-1:0]     i_req_addr,
    input  wire                   i_req_ren,
    input  wire                   i_req_wen,
    input  wire  [MASK_W-1:0]     i_req_mask,
    input  wire  [DATA_W-1:0]     i_req_wdata,
    // memory status
    input  wire                   i_mem_ready,
    input  wire                   i_mem_valid,
    // lookup results from the stores
    input  wire                   i_hit,
    input  wire                   i_hit_way,
    input  wire                   i_victim_way,
    input  wire  [DATA_W-1:0]     i_rd_word,
    output logic                  o_busy,
    // memory drive
    output logic [ADDR_W-1:0]     o_mem_addr,
    output logic                  o_mem_ren,
    output logic                  o_mem_wen,
    output logic [DATA_W-1:0]     o_mem_wdata,
    // store control
    output logic                  o_hit_update,
    output logic                  o_fill_we,
    output logic [ADDR_W-1:0]     o_fill_addr,
    output logic                  o_fill_way,
    output logic [WORD_SEL_W-1:0] o_fill_word_sel,
    output logic                  o_fill_done,
    output logic                  o_store_we,
    output logic                  o_store_way,
    output logic [ADDR_W-1:0]     o_store_addr,
    output logic [DATA_W-1:0]     o_store_word
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // refill word counter, wraps back to zero after the last word
    logic [WORD_SEL_W-1:0] fill_cnt_q;

    // request captured at the start of a stall
    logic [ADDR_W-1:0] cap_addr_q;
    logic [MASK_W-1:0] cap_mask_q;
    logic [DATA_W-1:0] cap_wdata_q;
    logic              cap_is_store_q;
    logic              capture;

    logic              req_any;
    logic              in_lookup;
    logic [ADDR_W-1:0] act_addr;
    logic [MASK_W-1:0] merge_mask;
    logic [DATA_W-1:0] merge_data;
    logic [DATA_W-1:0] merged_word;

    assign req_any   = i_req_ren | i_req_wen;
    assign in_lookup = (state_q == LOOKUP);

    // in LOOKUP the live request drives everything, afterwards the captured copy
    assign act_addr   = in_lookup ? i_req_addr  : cap_addr_q;
    assign merge_mask = in_lookup ? i_req_mask  : cap_mask_q;
    assign merge_data = in_lookup ? i_req_wdata : cap_wdata_q;

    ////////////////////////////////////////////////////////////////////
    // byte merge
    ////////////////////////////////////////////////////////////////////

    // masked bytes come from the store data, the rest from the cached word
    always_comb begin
        for (int b = 0; b < MASK_W; b++) begin
            merged_word[8*b +: 8] = merge_mask[b] ? merge_data[8*b +: 8]
                                                  : i_rd_word[8*b +: 8];
        end
    end

    assign o_mem_wdata  = merged_word;
    assign o_store_word = merged_word;
    assign o_store_addr = act_addr;
    // the way that hit is also the one just refilled after a store miss
    assign o_store_way  = i_hit_way;

    assign o_fill_addr     = cap_addr_q;
    assign o_fill_way      = i_victim_way;
    assign o_fill_word_sel = fill_cnt_q;

    // any hit in LOOKUP counts, including a store hit that has to stall
    assign o_hit_update = in_lookup && req_any && i_hit;

    ////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        capture     = 1'b0;
        o_busy      = 1'b0;
        o_mem_ren   = 1'b0;
        o_mem_wen   = 1'b0;
        o_fill_we   = 1'b0;
        o_fill_done = 1'b0;
        o_store_we  = 1'b0;
        // word aligned address of the active request
        o_mem_addr  = {act_addr[ADDR_W-1:OFFSET_W-WORD_SEL_W], {(OFFSET_W-WORD_SEL_W){1'b0}}};

        case (state_q)
            LOOKUP: begin
                if (req_any && !i_hit) begin
                    // miss of either kind starts a line refill
                    o_busy  = 1'b1;
                    capture = 1'b1;
                    state_d = FILL_REQ;
                end else if (i_req_wen && i_hit) begin
                    if (i_mem_ready) begin
                        // write through in the same cycle as the cache update
                        o_mem_wen  = 1'b1;
                        o_store_we = 1'b1;
                    end else begin
                        o_busy  = 1'b1;
                        capture = 1'b1;
                        state_d = WRITE_THRU;
                    end
                end
            end

            FILL_REQ: begin
                o_busy     = 1'b1;
                o_mem_addr = {cap_addr_q[ADDR_W-1:OFFSET_W], fill_cnt_q,
                              {(OFFSET_W-WORD_SEL_W){1'b0}}};
                if (i_mem_ready) begin
                    o_mem_ren = 1'b1;
                    state_d   = FILL_WAIT;
                end
            end

            FILL_WAIT: begin
                o_busy = 1'b1;
                if (i_mem_valid) begin
                    o_fill_we = 1'b1;
                    if (&fill_cnt_q) begin
                        // line is complete, a store still has to merge
                        o_fill_done = 1'b1;
                        state_d     = cap_is_store_q ? WRITE_THRU : LOOKUP;
                    end else begin
                        state_d = FILL_REQ;
                    end
                end
            end

            WRITE_THRU: begin
                // busy holds through the write so the hart sees it end next cycle
                o_busy = 1'b1;
                if (i_mem_ready) begin
                    o_mem_wen  = 1'b1;
                    o_store_we = 1'b1;
                    state_d    = LOOKUP;
                end
            end

            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q        <= LOOKUP;
            fill_cnt_q     <= '0;
            cap_is_store_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_fill_we) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
            if (capture) begin
                cap_is_store_q <= i_req_wen;
            end
        end
    end

    // payload of the captured request
    always_ff @(posedge i_clk) begin
        if (capture) begin
            cap_addr_q  <= i_req_addr;
            cap_mask_q  <= i_req_mask;
            cap_wdata_q <= i_req_wdata;
        end
    end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  wire               i_clk,
    input  wire               i_rst,
    // hart side
    input  wire  [ADDR_W-1:0] i_req_addr,
    input  wire               i_req_ren,
    input  wire               i_req_wen,
    input  wire  [MASK_W-1:0] i_req_mask,
    input  wire  [DATA_W-1:0] i_req_wdata,
    output logic              o_busy,
    output logic [DATA_W-1:0] o_res_rdata,
    // memory side
    input  wire               i_mem_ready,
    input  wire               i_mem_valid,
    input  wire  [DATA_W-1:0] i_mem_rdata,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic              o_mem_ren,
    output logic              o_mem_wen,
    output logic [DATA_W-1:0] o_mem_wdata
);

    // lookup results
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;

    // store control from the FSM
    logic                  hit_update;
    logic                  fill_we;
    logic [ADDR_W-1:0]     fill_addr;
    logic                  fill_way;
    logic [WORD_SEL_W-1:0] fill_word_sel;
    logic                  fill_done;
    logic                  store_we;
    logic                  store_way;
    logic [ADDR_W-1:0]     store_addr;
    logic [DATA_W-1:0]     store_word;

    cache_tag_store tag_store_inst (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_addr   (i_req_addr),
        .i_fill_addr  (fill_addr),
        .i_hit_update (hit_update),
        .i_fill_done  (fill_done),
        .i_fill_way   (fill_way),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_victim_way (victim_way)
    );

    // the read word goes to the hart and back to the FSM for merging
    cache_data_store data_store_inst (
        .i_clk           (i_clk),
        .i_req_addr      (i_req_addr),
        .i_hit_way       (hit_way),
        .i_fill_we       (fill_we),
        .i_fill_way      (fill_way),
        .i_fill_addr     (fill_addr),
        .i_fill_word_sel (fill_word_sel),
        .i_mem_rdata     (i_mem_rdata),
        .i_store_we      (store_we),
        .i_store_way     (store_way),
        .i_store_addr    (store_addr),
        .i_store_word    (store_word),
        .o_rd_word       (o_res_rdata)
    );

    cache_ctrl ctrl_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_req_addr      (i_req_addr),
        .i_req_ren       (i_req_ren),
        .i_req_wen       (i_req_wen),
        .i_req_mask      (i_req_mask),
        .i_req_wdata     (i_req_wdata),
        .i_mem_ready     (i_mem_ready),
        .i_mem_valid     (i_mem_valid),
        .i_hit           (hit),
        .i_hit_way       (hit_way),
        .i_victim_way    (victim_way),
        .i_rd_word       (o_res_rdata),
        .o_busy          (o_busy),
        .o_mem_addr      (o_mem_addr),
        .o_mem_ren       (o_mem_ren),
        .o_mem_wen       (o_mem_wen),
        .o_mem_wdata     (o_mem_wdata),
        .o_hit_update    (hit_update),
        .o_fill_we       (fill_we),
        .o_fill_addr     (fill_addr),
        .o_fill_way      (fill_way),
        .o_fill_word_sel (fill_word_sel),
        .o_fill_done     (fill_done),
        .o_store_we      (store_we),
        .o_store_way     (store_way),
        .o_store_addr    (store_addr),
        .o_store_word    (store_word)
    );

endmodule

`default_nettype wire

/* cache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_asserts (
    input wire i_clk,
    input wire i_rst,
    input wire i_mem_ready,
    input wire i_mem_ren,
    input wire i_mem_wen,
    input wire i_busy
);

    //////////////////////////////////////////////////////////////////////
    // memory port protocol
    //////////////////////////////////////////////////////////////////////

    // the memory port carries one command per cycle
    one_strobe_a: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_mem_ren && i_mem_wen))
        else $error("memory read and write strobes high in the same cycle");

    // a strobe is only a request when memory can take it
    strobe_ready_a: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_ren || i_mem_wen) |-> i_mem_ready)
        else $error("memory strobe issued while memory was not ready");

    // the FSM leaves reset idle with the memory port quiet
    reset_idle_a: assert property (@(posedge i_clk)
        ($past(i_rst) && !i_rst) |-> (!i_busy && !i_mem_ren && !i_mem_wen))
        else $error("cache not idle in the first cycle after reset");

endmodule

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache import cache_pkg::*;;

    // cycles one request may stay busy before the run gives up
    localparam int BUSY_TIMEOUT = 200;

    // one row of the stimulus table
    typedef struct packed {
        logic              is_store;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic [DATA_W-1:0] wdata;
        logic              exp_hit;
        // memory ready is held low in the request cycle
        logic              stall;
    } row_t;

    logic              i_clk = 1'b0;
    logic              i_rst;
    logic [ADDR_W-1:0] i_req_addr;
    logic              i_req_ren;
    logic              i_req_wen;
    logic [MASK_W-1:0] i_req_mask;
    logic [DATA_W-1:0] i_req_wdata;
    logic              i_mem_ready = 1'b0;
    logic              i_mem_valid = 1'b0;
    logic [DATA_W-1:0] i_mem_rdata = '0;
    logic              o_busy;
    logic [DATA_W-1:0] o_res_rdata;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              o_mem_ren;
    logic              o_mem_wen;
    logic [DATA_W-1:0] o_mem_wdata;

    // sparse memory as the DUT sees it, and the expected contents
    logic [DATA_W-1:0] mem_words [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] exp_words [logic [ADDR_W-1:0]];
    // every read and write the memory model observed, in order
    logic [ADDR_W-1:0] rd_log [$];
    logic [ADDR_W-1:0] wr_addr_log [$];
    logic [DATA_W-1:0] wr_data_log [$];
    logic [ADDR_W-1:0] rd_addr = '0;
    int                rd_delay = 0;
    bit                rd_pending = 1'b0;
    bit                hold_off = 1'b0;

    row_t rows [$];
    int   error_count;
    int   timeout_count;
    int   check_count;

    always #10 i_clk = ~i_clk;

    cache_top cache_top_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_addr  (i_req_addr),
        .i_req_ren   (i_req_ren),
        .i_req_wen   (i_req_wen),
        .i_req_mask  (i_req_mask),
        .i_req_wdata (i_req_wdata),
        .o_busy      (o_busy),
        .o_res_rdata (o_res_rdata),
        .i_mem_ready (i_mem_ready),
        .i_mem_valid (i_mem_valid),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_addr  (o_mem_addr),
        .o_mem_ren   (o_mem_ren),
        .o_mem_wen   (o_mem_wen),
        .o_mem_wdata (o_mem_wdata)
    );

    bind cache_ctrl cache_asserts ctrl_asserts_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_mem_ready (i_mem_ready),
        .i_mem_ren   (o_mem_ren),
        .i_mem_wen   (o_mem_wen),
        .i_busy      (o_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // untouched memory holds a pattern mixed from every address bit
    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h3C5A_0F81;
    endfunction

    function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return init_word(addr);
    endfunction

    function automatic logic [DATA_W-1:0] exp_read(input logic [ADDR_W-1:0] addr);
        if (exp_words.exists(addr)) begin
            return exp_words[addr];
        end
        return init_word(addr);
    endfunction

    // bytes with their mask bit set come from the new data
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic report_fail(input string msg);
        error_count++;
        $display("FAIL %0d ns: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    // one read is in flight at a time and is answered after 1 to 4 cycles
    always @(posedge i_clk) begin
        if (i_rst) begin
            i_mem_ready <= 1'b1;
            i_mem_valid <= 1'b0;
            rd_pending = 1'b0;
        end else begin
            i_mem_valid <= 1'b0;
            // ready drops in about one cycle out of four
            if (hold_off) begin
                i_mem_ready <= 1'b0;
            end else begin
                i_mem_ready <= ($urandom % 4) != 0;
            end
            if (rd_pending) begin
                if (rd_delay == 1) begin
                    i_mem_valid <= 1'b1;
                    i_mem_rdata <= mem_read(rd_addr);
                    rd_pending = 1'b0;
                end else begin
                    rd_delay = rd_delay - 1;
                end
            end
            if (o_mem_ren) begin
                rd_log.push_back(o_mem_addr);
                rd_addr    = o_mem_addr;
                rd_delay   = 1 + int'($urandom % 4);
                rd_pending = 1'b1;
            end
            if (o_mem_wen) begin
                mem_words[o_mem_addr] = o_mem_wdata;
                wr_addr_log.push_back(o_mem_addr);
                wr_data_log.push_back(o_mem_wdata);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input logic is_store, input logic [ADDR_W-1:0] addr,
                           input logic [MASK_W-1:0] mask, input logic [DATA_W-1:0] wdata,
                           input logic exp_hit, input logic stall);
        rows.push_back({is_store, addr, mask, wdata, exp_hit, stall});
    endtask

    // hit flags follow the victim bit of each set, which starts at way 0
    task automatic build_table();
        // set 0 takes a cold miss and then hits and partial stores on the same line
        add_row(1'b0, 32'h0000_1000, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_1004, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_1008, 4'b0011, 32'hDEAD_BEEF, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1008, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_100C, 4'b1100, 32'h1234_5678, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_100C, 4'h0, 32'h0, 1'b1, 1'b0);
        // in set 2 a store miss allocates the line
        add_row(1'b1, 32'h0000_2024, 4'b0100, 32'h00AB_0000, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2024, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_2028, 4'h0, 32'h0, 1'b1, 1'b0);
        // set 5 with lines A, B and C, where C evicts B and B then evicts C
        add_row(1'b0, 32'h0000_3050, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_3254, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_3058, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_3450, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_305C, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_3250, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_3454, 4'h0, 32'h0, 1'b0, 1'b0);
        // set 0 again takes full and single byte stores
        add_row(1'b1, 32'h0000_1000, 4'b1111, 32'hCAFE_F00D, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1000, 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_1004, 4'b1000, 32'h7700_0000, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_1004, 4'h0, 32'h0, 1'b1, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // row execution
    //////////////////////////////////////////////////////////////////////

    task automatic run_row(input int idx, output bit ok);
        row_t              row;
        logic [ADDR_W-1:0] aligned;
        logic [ADDR_W-1:0] line_base;
        logic [DATA_W-1:0] exp_word;
        logic              busy_exp;
        int                rd_start;
        int                wr_start;
        int                cycles;
        row       = rows[idx];
        aligned   = {row.addr[ADDR_W-1:2], 2'b00};
        line_base = {row.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        rd_start  = rd_log.size();
        wr_start  = wr_addr_log.size();
        ok        = 1'b1;

        // in the request cycle a store hit against a stalled memory must stall too
        hold_off = row.stall;
        @(posedge i_clk);
        i_req_addr  <= row.addr;
        i_req_ren   <= !row.is_store;
        i_req_wen   <= row.is_store;
        i_req_mask  <= row.mask;
        i_req_wdata <= row.wdata;
        @(negedge i_clk);
        hold_off = 1'b0;
        busy_exp = !row.exp_hit || (row.is_store && !i_mem_ready);
        check_count++;
        if (o_busy !== busy_exp) begin
            report_fail($sformatf("row %0d busy %b in request cycle, expected %b",
                                  idx, o_busy, busy_exp));
        end
        if (!row.is_store && row.exp_hit) begin
            check_count++;
            if (o_res_rdata !== exp_read(aligned)) begin
                report_fail($sformatf("row %0d load hit at %08h read %08h, expected %08h",
                                      idx, row.addr, o_res_rdata, exp_read(aligned)));
            end
        end

        // the hart drops its strobe and keeps the address until busy falls
        @(posedge i_clk);
        i_req_ren <= 1'b0;
        i_req_wen <= 1'b0;
        cycles = 0;
        @(negedge i_clk);
        while (o_busy !== 1'b0 && cycles < BUSY_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_busy !== 1'b0) begin
            timeout_count++;
            $display("timeout: row %0d still busy after %0d cycles", idx, BUSY_TIMEOUT);
            ok = 1'b0;
            return;
        end

        if (row.is_store) begin
            exp_word             = merge_bytes(exp_read(aligned), row.wdata, row.mask);
            exp_words[aligned]   = exp_word;
            check_count++;
            if (wr_addr_log.size() != wr_start + 1) begin
                report_fail($sformatf("row %0d store wrote %0d words to memory",
                                      idx, wr_addr_log.size() - wr_start));
            end else if (wr_addr_log[wr_start] !== aligned ||
                         wr_data_log[wr_start] !== exp_word) begin
                report_fail($sformatf("row %0d wrote %08h to %08h, expected %08h to %08h",
                                      idx, wr_data_log[wr_start], wr_addr_log[wr_start],
                                      exp_word, aligned));
            end
        end else begin
            check_count++;
            if (o_res_rdata !== exp_read(aligned)) begin
                report_fail($sformatf("row %0d load at %08h read %08h, expected %08h",
                                      idx, row.addr, o_res_rdata, exp_read(aligned)));
            end
            if (wr_addr_log.size() != wr_start) begin
                report_fail($sformatf("row %0d load wrote to memory", idx));
            end
        end

        // a miss reads the four words of the line in order, a hit reads nothing
        check_count++;
        if (row.exp_hit) begin
            if (rd_log.size() != rd_start) begin
                report_fail($sformatf("row %0d hit issued %0d memory reads",
                                      idx, rd_log.size() - rd_start));
            end
        end else if (rd_log.size() != rd_start + WORDS_PER_LINE) begin
            report_fail($sformatf("row %0d miss issued %0d memory reads",
                                  idx, rd_log.size() - rd_start));
        end else begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                if (rd_log[rd_start+k] !== line_base + ADDR_W'(4 * k)) begin
                    report_fail($sformatf("row %0d refill read %0d at %08h, expected %08h",
                                          idx, k, rd_log[rd_start+k],
                                          line_base + ADDR_W'(4 * k)));
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int seed_word;
        bit ok;
        seed_word     = $urandom(67);
        i_rst         = 1'b1;
        i_req_addr    = '0;
        i_req_ren     = 1'b0;
        i_req_wen     = 1'b0;
        i_req_mask    = '0;
        i_req_wdata   = '0;
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        ok            = 1'b1;
        build_table();

        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_count++;
        if (o_busy !== 1'b0 || o_mem_ren !== 1'b0 || o_mem_wen !== 1'b0) begin
            report_fail($sformatf("after reset busy %b ren %b wen %b",
                                  o_busy, o_mem_ren, o_mem_wen));
        end

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, ok);
            if (!ok) begin
                break;
            end
        end

        $display("checks %0d, mismatches %0d, timeouts %0d (seed word %08h)",
                 check_count, error_count, timeout_count, seed_word);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wt_cache.f */
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
cache_top.sv
cache_asserts.sv
tb_cache.sv

/* run.sh */
#!/bin/sh
# compiles the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
        -f wt_cache.f -o tb_cache_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cache_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
